// ==== dmem_fabric.f ====
+incdir+include
verilog/dmem_pkg.sv
verilog/dmem_router.sv
verilog/dmem_tcm.sv
verilog/dmem_timer.sv
verilog/dmem_fabric_top.sv
dv/tb_dmem_fabric.sv

// ==== Makefile ====
# Verilator build and run for the data memory fabric

VERILATOR  ?= verilator
TOP        ?= tb_dmem_fabric
DUT_TOP    ?= dmem_fabric_top
FILELIST   ?= dmem_fabric.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
PASS_TEXT  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_dmem_fabric.sv ====
`timescale 1ns/1ps

`include "dmem_fabric_config.svh"

module tb_dmem_fabric;

    import dmem_pkg::*;

    localparam int TCM_WORDS_USED = 64;
    localparam int NUM_TCM        = 300;
    localparam int NUM_EXT        = 200;
    localparam int NUM_TXN        = TCM_WORDS_USED + NUM_TCM + NUM_EXT + 40;
    localparam int CYCLE_LIMIT    = 20 * NUM_TXN + 2000;

    logic           clk;
    logic           core_rst_n_local;
    logic           core_req_i;
    dmem_req_t      core_req_data_i;
    logic           core_req_ack_o;
    dmem_rsp_t      core_rsp_o;
    logic           ext_req_o;
    dmem_req_t      ext_req_data_o;
    logic           ext_req_ack_i;
    dmem_rsp_t      ext_rsp_i;
    logic [63:0]    timer_val_o;
    logic           timer_irq_o;

    logic [31:0]    rng_state;
    int             cycle_cnt;
    logic [31:0]    tcm_model [TCM_WORDS_USED];
    logic [31:0]    ext_mem [logic [29:0]];     // Sparse and word addressed
    logic [9:0]     model_div;
    logic [63:0]    model_mtime;
    logic [63:0]    model_cmp;

    dmem_fabric_top dut (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .core_req_i         (core_req_i      ),
        .core_req_data_i    (core_req_data_i ),
        .core_req_ack_o     (core_req_ack_o  ),
        .core_rsp_o         (core_rsp_o      ),
        .ext_req_o          (ext_req_o       ),
        .ext_req_data_o     (ext_req_data_o  ),
        .ext_req_ack_i      (ext_req_ack_i   ),
        .ext_rsp_i          (ext_rsp_i       ),
        .timer_val_o        (timer_val_o     ),
        .timer_irq_o        (timer_irq_o     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] lane_mask(input mem_width_e w, input logic [1:0] ofs);
        case (w)
            MEM_WIDTH_BYTE:  return 32'h0000_00FF << {ofs, 3'b000};
            MEM_WIDTH_HWORD: return 32'h0000_FFFF << {ofs[1], 4'b0000};
            default:         return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic is_misaligned(input mem_width_e w, input logic [1:0] ofs);
        return ((w == MEM_WIDTH_HWORD) && ofs[0]) || ((w == MEM_WIDTH_WORD) && (ofs != 2'b00));
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic is_internal(input logic [31:0] addr);
        return ((addr & `TCM_ADDR_MASK) == `TCM_ADDR_PATTERN) ||
               ((addr & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN);
    endfunction

    // No request to and no response from the TCM or the timer
    function automatic logic internal_ports_idle();
        return !dut.tcm_req && !dut.timer_req &&
               (dut.tcm_rsp.resp == MEM_RESP_NOTRDY) &&
               (dut.timer_rsp.resp == MEM_RESP_NOTRDY);
    endfunction

    // One core transaction entered and left on a falling edge
    task automatic bus_access(input dmem_req_t req, output mem_resp_e resp,
                              output logic [31:0] rdata);
        int          ack_dly;
        int          rsp_dly;
        logic [29:0] wa;
        logic [31:0] m;
        logic [31:0] rd;
        ack_dly = int'(lcg_next() % 4);
        rsp_dly = int'(lcg_next() % 4);
        core_req_i      = 1'b1;
        core_req_data_i = req;
        if (!is_internal(req.addr)) begin
            for (int i = 0; i < ack_dly; i++) begin
                #1;
                assert (ext_req_o && (ext_req_data_o == req) && !core_req_ack_o)
                    else report_mismatch("external request not held while waiting for ack");
                @(negedge clk);
            end
            ext_req_ack_i = 1'b1;
            #1;
            assert (ext_req_o && (ext_req_data_o == req) && core_req_ack_o)
                else report_mismatch("external request or ack wrong at acceptance");
            assert (internal_ports_idle())
                else report_mismatch("TCM or timer port active during an external access");
            @(negedge clk);
            core_req_i    = 1'b0;
            ext_req_ack_i = 1'b0;
            // Responder side of the external memory
            wa = req.addr[31:2];
            rd = ext_mem.exists(wa) ? ext_mem[wa] : fill_word({wa, 2'b00});
            if (req.cmd == MEM_CMD_WR) begin
                m = lane_mask(req.width, req.addr[1:0]);
                ext_mem[wa] = (rd & ~m) | (req.wdata & m);
            end
            for (int i = 0; i < rsp_dly; i++) begin
                #1;
                assert (core_rsp_o.resp == MEM_RESP_NOTRDY)
                    else report_mismatch("response seen before external memory answered");
                assert (internal_ports_idle())
                    else report_mismatch("TCM or timer port active during an external access");
                @(negedge clk);
            end
            ext_rsp_i.resp  = MEM_RESP_RDY_OK;
            ext_rsp_i.rdata = rd;
            #1;
            assert (internal_ports_idle())
                else report_mismatch("TCM or timer port active during an external access");
            resp  = core_rsp_o.resp;
            rdata = core_rsp_o.rdata;
            @(negedge clk);
            ext_rsp_i.resp  = MEM_RESP_NOTRDY;
            ext_rsp_i.rdata = '0;
        end else begin
            #1;
            assert (core_req_ack_o)
                else report_mismatch("internal request not acked at once");
            @(negedge clk);
            core_req_i = 1'b0;
            #1;
            assert (core_rsp_o.resp != MEM_RESP_NOTRDY)
                else report_mismatch("internal response not one cycle after acceptance");
            resp  = core_rsp_o.resp;
            rdata = core_rsp_o.rdata;
            @(negedge clk);
        end
    endtask

    task automatic timer_write(input logic [4:0] ofs, input logic [31:0] data);
        dmem_req_t   req;
        mem_resp_e   resp;
        logic [31:0] rd;
        req.cmd   = MEM_CMD_WR;
        req.width = MEM_WIDTH_WORD;
        req.addr  = `TIMER_ADDR_PATTERN | {27'd0, ofs};
        req.wdata = data;
        bus_access(req, resp, rd);
        assert (resp == MEM_RESP_RDY_OK)
            else report_mismatch($sformatf("timer write to offset %0h not OK", ofs));
    endtask

    task automatic timer_check(input logic [4:0] ofs, input logic [31:0] exp);
        dmem_req_t   req;
        mem_resp_e   resp;
        logic [31:0] rd;
        req.cmd   = MEM_CMD_RD;
        req.width = MEM_WIDTH_WORD;
        req.addr  = `TIMER_ADDR_PATTERN | {27'd0, ofs};
        req.wdata = '0;
        bus_access(req, resp, rd);
        assert ((resp == MEM_RESP_RDY_OK) && (rd == exp))
            else report_mismatch($sformatf("timer offset %0h read %h, expected %h",
                                           ofs, rd, exp));
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        dmem_req_t   req;
        mem_resp_e   resp;
        logic [31:0] rd;
        logic [31:0] r;
        logic [5:0]  widx;
        logic [31:0] m;
        logic [63:0] prev_val;
        int          since;
        logic        seen_change;
        logic        irq_seen;
        int          after_irq;

        rng_state        = 32'h8fd6;
        cycle_cnt        = 0;
        core_rst_n_local = 1'b0;
        core_req_i       = 1'b0;
        core_req_data_i  = '0;
        ext_req_ack_i    = 1'b0;
        ext_rsp_i        = '0;
        repeat (2) @(negedge clk);
        core_rst_n_local = 1'b1;
        #1;
        assert (!ext_req_o && (core_rsp_o.resp == MEM_RESP_NOTRDY) && !timer_irq_o)
            else report_mismatch("outputs not idle after reset");
        @(negedge clk);

        // Known contents for the TCM words in use
        for (int i = 0; i < TCM_WORDS_USED; i++) begin
            req.cmd   = MEM_CMD_WR;
            req.width = MEM_WIDTH_WORD;
            req.addr  = 32'(i) << 2;
            req.wdata = fill_word(req.addr);
            tcm_model[i] = req.wdata;
            bus_access(req, resp, rd);
            assert (resp == MEM_RESP_RDY_OK) else report_mismatch("TCM fill write failed");
        end

        // TCM random traffic with misaligned accesses mixed in
        for (int n = 0; n < NUM_TCM; n++) begin
            r         = lcg_next();
            widx      = r[7:2];
            req.addr  = {24'd0, widx, r[1:0]};
            req.width = mem_width_e'(2'(r[11:8] % 3));
            req.cmd   = mem_cmd_e'(r[12]);
            req.wdata = lcg_next();
            bus_access(req, resp, rd);
            if (is_misaligned(req.width, req.addr[1:0])) begin
                assert (resp == MEM_RESP_RDY_ER)
                    else report_mismatch($sformatf("misaligned TCM access %h not ER", req.addr));
            end else if (req.cmd == MEM_CMD_WR) begin
                assert (resp == MEM_RESP_RDY_OK) else report_mismatch("TCM write not OK");
                m = lane_mask(req.width, req.addr[1:0]);
                tcm_model[widx] = (tcm_model[widx] & ~m) | (req.wdata & m);
            end else begin
                assert ((resp == MEM_RESP_RDY_OK) && (rd == tcm_model[widx]))
                    else report_mismatch($sformatf("TCM read %h got %h, expected %h",
                                                   req.addr, rd, tcm_model[widx]));
            end
        end

        // Aligned external accesses outside both windows
        for (int n = 0; n < NUM_EXT; n++) begin
            r = lcg_next();
            while (is_internal(r)) begin
                r = lcg_next();
            end
            req.width = mem_width_e'(2'(lcg_next() % 3));
            req.addr  = (req.width == MEM_WIDTH_WORD)  ? {r[31:2], 2'b00} :
                        (req.width == MEM_WIDTH_HWORD) ? {r[31:1], 1'b0} : r;
            req.cmd   = mem_cmd_e'(r[4]);
            req.wdata = lcg_next();
            rd = ext_mem.exists(req.addr[31:2]) ? ext_mem[req.addr[31:2]]
                                                : fill_word({req.addr[31:2], 2'b00});
            m = rd;     // Expected read word taken before the access
            bus_access(req, resp, rd);
            assert (resp == MEM_RESP_RDY_OK) else report_mismatch("external access not OK");
            if (req.cmd == MEM_CMD_RD) begin
                assert (rd == m)
                    else report_mismatch($sformatf("external read %h got %h, expected %h",
                                                   req.addr, rd, m));
            end
        end

        // --------------------
        // Timer registers with counting off
        // --------------------
        r           = lcg_next();
        model_div   = r[9:0];
        model_mtime = {lcg_next(), lcg_next()};
        model_cmp   = {lcg_next(), lcg_next()};
        timer_write(`TIMER_OFS_CTRL, 32'h0);
        timer_write(`TIMER_OFS_DIV, r);
        timer_write(`TIMER_OFS_MTIME_LO, model_mtime[31:0]);
        timer_write(`TIMER_OFS_MTIME_HI, model_mtime[63:32]);
        timer_write(`TIMER_OFS_MTIMECMP_LO, model_cmp[31:0]);
        timer_write(`TIMER_OFS_MTIMECMP_HI, model_cmp[63:32]);
        timer_check(`TIMER_OFS_CTRL, 32'h0);
        timer_check(`TIMER_OFS_DIV, {22'd0, model_div});
        timer_check(`TIMER_OFS_MTIME_LO, model_mtime[31:0]);
        timer_check(`TIMER_OFS_MTIME_HI, model_mtime[63:32]);
        timer_check(`TIMER_OFS_MTIMECMP_LO, model_cmp[31:0]);
        timer_check(`TIMER_OFS_MTIMECMP_HI, model_cmp[63:32]);
        assert ((timer_val_o == model_mtime) && (timer_irq_o == (model_mtime >= model_cmp)))
            else report_mismatch("timer value or interrupt wrong with counting off");

        // Non-word widths and unlisted offsets
        for (int n = 0; n < 4; n++) begin
            req.cmd   = mem_cmd_e'(n[0]);
            req.width = (n < 2) ? MEM_WIDTH_BYTE : MEM_WIDTH_WORD;
            req.addr  = `TIMER_ADDR_PATTERN | ((n < 2) ? 32'h08 : 32'h18 + 32'(n[0]) * 4);
            req.wdata = lcg_next();
            bus_access(req, resp, rd);
            assert (resp == MEM_RESP_RDY_ER)
                else report_mismatch($sformatf("bad timer access %h not ER", req.addr));
        end
        timer_check(`TIMER_OFS_MTIME_LO, model_mtime[31:0]);

        // --------------------
        // Timer counting
        // --------------------
        model_div = 10'(lcg_next() % 8);
        model_cmp = 64'(20 + lcg_next() % 20);
        timer_write(`TIMER_OFS_MTIME_LO, 32'h0);
        timer_write(`TIMER_OFS_MTIME_HI, 32'h0);
        timer_write(`TIMER_OFS_MTIMECMP_HI, 32'h0);
        timer_write(`TIMER_OFS_MTIMECMP_LO, model_cmp[31:0]);
        timer_write(`TIMER_OFS_DIV, {22'd0, model_div});
        timer_write(`TIMER_OFS_CTRL, 32'h1);
        prev_val    = timer_val_o;
        since       = 0;
        seen_change = 1'b0;
        irq_seen    = 1'b0;
        after_irq   = 0;
        for (int c = 0; c < 700 && after_irq < 20; c++) begin
            @(negedge clk);
            #1;
            since++;
            assert (timer_irq_o == (timer_val_o >= model_cmp))
                else report_mismatch("timer interrupt disagrees with compare");
            assert (timer_val_o >= prev_val)
                else report_mismatch("timer value went backwards");
            if (timer_val_o != prev_val) begin
                assert (!seen_change || (since >= int'(model_div) + 1))
                    else report_mismatch($sformatf("timer stepped after %0d cycles, div %0d",
                                                   since, model_div));
                seen_change = 1'b1;
                since       = 0;
                prev_val    = timer_val_o;
            end
            if (timer_irq_o) begin
                irq_seen = 1'b1;
            end
            if (irq_seen) begin
                after_irq++;
            end
        end
        assert (irq_seen) else report_error("timer interrupt never rose while counting");

        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_dmem_fabric

// ==== verilog/dmem_fabric_top.sv ====
`timescale 1ns/1ps

module dmem_fabric_top (
    input  logic                    clk,
    input  logic                    core_rst_n_local,

    // Core data memory port
    input  logic                    core_req_i,
    input  dmem_pkg::dmem_req_t     core_req_data_i,
    output logic                    core_req_ack_o,
    output dmem_pkg::dmem_rsp_t     core_rsp_o,

    // External memory port
    output logic                    ext_req_o,
    output dmem_pkg::dmem_req_t     ext_req_data_o,
    input  logic                    ext_req_ack_i,
    input  dmem_pkg::dmem_rsp_t     ext_rsp_i,

    // Timer
    output logic [63:0]             timer_val_o,
    output logic                    timer_irq_o
);

    import dmem_pkg::*;

    logic           tcm_req;
    dmem_rsp_t      tcm_rsp;
    logic           timer_req;
    dmem_rsp_t      timer_rsp;

    // --------------------
    // Router
    // --------------------
    dmem_router i_router (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .core_req_i         (core_req_i      ),
        .core_req_data_i    (core_req_data_i ),
        .core_req_ack_o     (core_req_ack_o  ),
        .core_rsp_o         (core_rsp_o      ),
        .tcm_req_o          (tcm_req         ),
        .tcm_rsp_i          (tcm_rsp         ),
        .timer_req_o        (timer_req       ),
        .timer_rsp_i        (timer_rsp       ),
        .ext_req_o          (ext_req_o       ),
        .ext_req_ack_i      (ext_req_ack_i   ),
        .ext_rsp_i          (ext_rsp_i       ),
        .port_req_data_o    (ext_req_data_o  )   // Shared bus that also feeds TCM and timer
    );

    dmem_tcm i_tcm (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .req_i              (tcm_req         ),
        .req_data_i         (ext_req_data_o  ),
        .rsp_o              (tcm_rsp         )
    );

    dmem_timer i_timer (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .req_i              (timer_req       ),
        .req_data_i         (ext_req_data_o  ),
        .rsp_o              (timer_rsp       ),
        .timer_val_o        (timer_val_o     ),
        .timer_irq_o        (timer_irq_o     )
    );

endmodule : dmem_fabric_top

// ==== verilog/dmem_timer.sv ====
`timescale 1ns/1ps

`include "dmem_fabric_config.svh"

module dmem_timer (
    input  logic                    clk,
    input  logic                    core_rst_n_local,

    // Register access
    input  logic                    req_i,
    input  dmem_pkg::dmem_req_t     req_data_i,
    output dmem_pkg::dmem_rsp_t     rsp_o,

    // Time and interrupt
    output logic [63:0]             timer_val_o,
    output logic                    timer_irq_o
);

    import dmem_pkg::*;

    localparam int DW = `TIMER_DIV_WIDTH;

    logic                       en_q;
    logic [DW-1:0]              div_q;
    logic [DW-1:0]              div_cnt;
    logic [63:0]                mtime;
    logic [63:0]                mtimecmp;
    logic [4:0]                 ofs;
    logic                       ofs_hit;
    logic                       acc_ok;
    logic                       wr;
    logic                       mtime_wr;
    logic                       tick;
    logic [`DMEM_DWIDTH-1:0]    rd_mux;
    mem_resp_e                  resp_q;
    logic [`DMEM_DWIDTH-1:0]    rdata_q;

    assign ofs = req_data_i.addr[4:0];

    // --------------------
    // Register decode
    // --------------------
    always_comb begin
        ofs_hit = 1'b1;
        case (ofs)
            `TIMER_OFS_CTRL:        rd_mux = {{(`DMEM_DWIDTH-1){1'b0}}, en_q};
            `TIMER_OFS_DIV:         rd_mux = `DMEM_DWIDTH'(div_q);
            `TIMER_OFS_MTIME_LO:    rd_mux = mtime[31:0];
            `TIMER_OFS_MTIME_HI:    rd_mux = mtime[63:32];
            `TIMER_OFS_MTIMECMP_LO: rd_mux = mtimecmp[31:0];
            `TIMER_OFS_MTIMECMP_HI: rd_mux = mtimecmp[63:32];
            default: begin
                rd_mux  = '0;
                ofs_hit = 1'b0;
            end
        endcase
    end

    assign acc_ok   = ofs_hit & (req_data_i.width == MEM_WIDTH_WORD);  // Word access only
    assign wr       = req_i & acc_ok & (req_data_i.cmd == MEM_CMD_WR);
    assign mtime_wr = wr & ((ofs == `TIMER_OFS_MTIME_LO) | (ofs == `TIMER_OFS_MTIME_HI));

    // --------------------
    // Control and compare
    // --------------------
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            en_q     <= 1'b0;
            div_q    <= '0;
            mtimecmp <= '1;     // No interrupt until programmed
        end else if (wr) begin
            case (ofs)
                `TIMER_OFS_CTRL:        en_q            <= req_data_i.wdata[0];
                `TIMER_OFS_DIV:         div_q           <= req_data_i.wdata[DW-1:0];
                `TIMER_OFS_MTIMECMP_LO: mtimecmp[31:0]  <= req_data_i.wdata;
                `TIMER_OFS_MTIMECMP_HI: mtimecmp[63:32] <= req_data_i.wdata;
                default: ;
            endcase
        end
    end

    // Divider gives one tick every div+1 clocks
    assign tick = en_q & (div_cnt == div_q);

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            div_cnt <= '0;
        end else if (~en_q | tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Software writes win over counting
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            mtime <= '0;
        end else if (mtime_wr) begin
            if (ofs == `TIMER_OFS_MTIME_LO) begin
                mtime[31:0] <= req_data_i.wdata;
            end else begin
                mtime[63:32] <= req_data_i.wdata;
            end
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    // --------------------
    // Response
    // --------------------
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_q <= MEM_RESP_NOTRDY;
        end else if (req_i) begin
            resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end else begin
            resp_q <= MEM_RESP_NOTRDY;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= rd_mux;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

    assign timer_val_o = mtime;
    assign timer_irq_o = (mtime >= mtimecmp);

    a_mtime_monotonic : assert property (
        @(posedge clk) disable iff (~core_rst_n_local)
        !mtime_wr |=> (mtime >= $past(mtime))
    );

endmodule : dmem_timer

// ==== verilog/dmem_tcm.sv ====
`timescale 1ns/1ps

`include "dmem_fabric_config.svh"

module dmem_tcm (
    input  logic                    clk,
    input  logic                    core_rst_n_local,
    input  logic                    req_i,
    input  dmem_pkg::dmem_req_t     req_data_i,
    output dmem_pkg::dmem_rsp_t     rsp_o
);

    import dmem_pkg::*;

    localparam int IDX_W = $clog2(`TCM_DEPTH_WORDS);
    localparam int LANES = `DMEM_DWIDTH / 8;

    logic [`DMEM_DWIDTH-1:0]    mem [`TCM_DEPTH_WORDS];
    logic [IDX_W-1:0]           idx;
    logic [1:0]                 ofs;
    logic [LANES-1:0]           be;         // Byte lane enables
    logic                       misaligned;
    logic                       wr_en;
    mem_resp_e                  resp_q;
    logic [`DMEM_DWIDTH-1:0]    rdata_q;

    assign idx = req_data_i.addr[IDX_W+1:2];
    assign ofs = req_data_i.addr[1:0];

    // --------------------
    // Lane decode
    // --------------------
    always_comb begin
        case (req_data_i.width)
            MEM_WIDTH_BYTE: begin
                be         = LANES'(1) << ofs;
                misaligned = 1'b0;
            end
            MEM_WIDTH_HWORD: begin
                be         = LANES'(3) << {ofs[1], 1'b0};
                misaligned = ofs[0];
            end
            MEM_WIDTH_WORD: begin
                be         = '1;
                misaligned = (ofs != 2'b00);
            end
            default: begin
                be         = '0;
                misaligned = 1'b1;   // Reserved width code
            end
        endcase
    end

    assign wr_en = req_i & (req_data_i.cmd == MEM_CMD_WR) & ~misaligned;

    // Storage where only the selected lanes change
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_en & be[i]) begin
                mem[idx][8*i +: 8] <= req_data_i.wdata[8*i +: 8];
            end
        end
        if (req_i) begin
            rdata_q <= mem[idx];    // Whole word for the core to pick lanes from
        end
    end

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_q <= MEM_RESP_NOTRDY;
        end else if (req_i) begin
            resp_q <= misaligned ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        end else begin
            resp_q <= MEM_RESP_NOTRDY;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

    a_addr_known : assert property (
        @(posedge clk) disable iff (~core_rst_n_local)
        req_i |-> !$isunknown(req_data_i.addr)
    );

endmodule : dmem_tcm

// ==== verilog/dmem_router.sv ====
`timescale 1ns/1ps

`include "dmem_fabric_config.svh"

module dmem_router (
    input  logic                    clk,
    input  logic                    core_rst_n_local,

    // Core side
    input  logic                    core_req_i,
    input  dmem_pkg::dmem_req_t     core_req_data_i,
    output logic                    core_req_ack_o,
    output dmem_pkg::dmem_rsp_t     core_rsp_o,

    // TCM port
    output logic                    tcm_req_o,
    input  dmem_pkg::dmem_rsp_t     tcm_rsp_i,

    // Timer port
    output logic                    timer_req_o,
    input  dmem_pkg::dmem_rsp_t     timer_rsp_i,

    // External port
    output logic                    ext_req_o,
    input  logic                    ext_req_ack_i,
    input  dmem_pkg::dmem_rsp_t     ext_rsp_i,

    // Request bus shared by all ports
    output dmem_pkg::dmem_req_t     port_req_data_o
);

    import dmem_pkg::*;

    localparam logic [1:0] PORT_EXT   = 2'd0;
    localparam logic [1:0] PORT_TCM   = 2'd1;
    localparam logic [1:0] PORT_TIMER = 2'd2;

    logic       [1:0]   port_sel;       // Decoded target of current request
    logic       [1:0]   port_q;         // Target of pending transaction
    logic               pending;
    dmem_rsp_t          rsp_sel;
    logic               rsp_done;
    logic               can_issue;
    logic               accept;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        if ((core_req_data_i.addr & `TCM_ADDR_MASK) == `TCM_ADDR_PATTERN) begin
            port_sel = PORT_TCM;
        end else if ((core_req_data_i.addr & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN) begin
            port_sel = PORT_TIMER;
        end else begin
            port_sel = PORT_EXT;
        end
    end

    // Response from the port that owns the pending transaction
    always_comb begin
        case (port_q)
            PORT_TCM:   rsp_sel = tcm_rsp_i;
            PORT_TIMER: rsp_sel = timer_rsp_i;
            default:    rsp_sel = ext_rsp_i;
        endcase
    end

    assign rsp_done  = pending & (rsp_sel.resp != MEM_RESP_NOTRDY);
    assign can_issue = ~pending | rsp_done;    // Back to back in the response cycle

    // --------------------
    // Request steering
    // --------------------
    assign tcm_req_o   = core_req_i & can_issue & (port_sel == PORT_TCM);
    assign timer_req_o = core_req_i & can_issue & (port_sel == PORT_TIMER);
    assign ext_req_o   = core_req_i & can_issue & (port_sel == PORT_EXT);

    assign port_req_data_o = core_req_data_i;

    // TCM and timer always accept while the external port has its own ack
    assign core_req_ack_o = can_issue & ((port_sel == PORT_EXT) ? ext_req_ack_i : 1'b1);
    assign accept         = core_req_i & core_req_ack_o;

    // Outstanding transaction tracking
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            pending <= 1'b0;
            port_q  <= PORT_EXT;
        end else if (accept) begin
            pending <= 1'b1;
            port_q  <= port_sel;
        end else if (rsp_done) begin
            pending <= 1'b0;
        end
    end

    always_comb begin
        if (pending) begin
            core_rsp_o = rsp_sel;
        end else begin
            core_rsp_o.resp  = MEM_RESP_NOTRDY;
            core_rsp_o.rdata = '0;
        end
    end

    // --------------------
    // Protocol checks
    // --------------------
    a_rsp_only_when_pending : assert property (
        @(posedge clk) disable iff (~core_rst_n_local)
        ((tcm_rsp_i.resp != MEM_RESP_NOTRDY) ||
         (timer_rsp_i.resp != MEM_RESP_NOTRDY) ||
         (ext_rsp_i.resp != MEM_RESP_NOTRDY)) |-> pending
    );

    a_core_req_stable : assert property (
        @(posedge clk) disable iff (~core_rst_n_local)
        (core_req_i && !core_req_ack_o) |=> (core_req_i && $stable(core_req_data_i))
    );

endmodule : dmem_router

// ==== verilog/dmem_pkg.sv ====
`include "dmem_fabric_config.svh"

package dmem_pkg;

    // --------------------
    // Protocol encodings
    // --------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,    // No response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Request as issued by the core with write data already lane placed
    typedef struct packed {
        mem_cmd_e                   cmd;
        mem_width_e                 width;
        logic [`DMEM_AWIDTH-1:0]    addr;
        logic [`DMEM_DWIDTH-1:0]    wdata;
    } dmem_req_t;

    // Response whose rdata is the full aligned word
    typedef struct packed {
        mem_resp_e                  resp;
        logic [`DMEM_DWIDTH-1:0]    rdata;
    } dmem_rsp_t;

endpackage : dmem_pkg

// ==== include/dmem_fabric_config.svh ====
`ifndef DMEM_FABRIC_CONFIG_SVH
`define DMEM_FABRIC_CONFIG_SVH

// --------------------
// Data bus widths
// --------------------
`define DMEM_AWIDTH             32
`define DMEM_DWIDTH             32

// --------------------
// Address map
// --------------------
`define TCM_ADDR_MASK           32'hFFFF_F000   // 4 KB window
`define TCM_ADDR_PATTERN        32'h0000_0000
`define TCM_DEPTH_WORDS         1024

`define TIMER_ADDR_MASK         32'hFFFF_FFE0   // 32 byte window
`define TIMER_ADDR_PATTERN      32'h0049_0000

// Timer sizes and register offsets
`define TIMER_DIV_WIDTH         10
`define TIMER_OFS_CTRL          5'h00
`define TIMER_OFS_DIV           5'h04
`define TIMER_OFS_MTIME_LO      5'h08
`define TIMER_OFS_MTIME_HI      5'h0C
`define TIMER_OFS_MTIMECMP_LO   5'h10
`define TIMER_OFS_MTIMECMP_HI   5'h14

`endif
